//--- common/core_params.svh
////////////////////////////////////////
// Core parameters
// Widths and sizes shared by the core
////////////////////////////////////////

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Accumulator and output port width
`define CORE_ACC_W 16

// Word program counter width
`define CORE_PC_W 16

// Instruction buffer entries, power of two
`define CORE_BUF_DEPTH 4

// Memory requests in flight
`define CORE_MAX_OUTST 2

`endif

//--- common/core_pkg.sv
////////////////////////////////////////
// Core package
// Opcodes, execute states and the
// instruction word layout
////////////////////////////////////////

`default_nettype none

package core_pkg;

  // Instruction opcodes
  // Unknown codes execute as NOP
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_LOADI = 8'h01,
    OP_ADDI  = 8'h02,
    OP_XORI  = 8'h03,
    OP_OUT   = 8'h04,
    OP_JMP   = 8'h05,
    OP_WFI   = 8'h06
  } opcode_e;

  // Instruction word as fetched from memory
  typedef struct packed {
    opcode_e     opcode;
    logic [7:0]  rsvd;
    logic [15:0] imm;
  } instr_t;

  // Execute unit run state
  typedef enum logic {
    EX_RUN   = 1'b0,
    EX_SLEEP = 1'b1
  } exec_state_e;

endpackage

`default_nettype wire

//--- common/instr_if.sv
////////////////////////////////////////
// Instruction stream interface
// Valid/ready transfer of one fetched
// instruction with its word PC
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

interface instr_if;

  // Forward path
  logic                  valid;
  core_pkg::instr_t      instr;
  logic [`CORE_PC_W-1:0] pc;

  // Backward path
  logic                  ready;
  // Drop everything upstream of the consumer
  logic                  flush;

  modport producer (
    output valid,
    output instr,
    output pc,
    input  ready,
    input  flush
  );

  modport consumer (
    input  valid,
    input  instr,
    input  pc,
    output ready,
    output flush
  );

endinterface

`default_nettype wire

//--- fetch/fetch_unit.sv
////////////////////////////////////////
// Fetch unit
// Issues instruction memory requests
// and forwards responses in order
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module fetch_unit (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 fetch_enable_i,
  input  logic [31:0]                          boot_addr_i,
  input  logic                                 sleep_i,
  input  logic [$clog2(`CORE_BUF_DEPTH+1)-1:0] buf_fill_i,
  input  logic                                 redirect_i,
  input  logic [`CORE_PC_W-1:0]                redirect_pc_i,
  output logic                                 instr_req_o,
  input  logic                                 instr_gnt_i,
  input  logic                                 instr_rvalid_i,
  output logic [31:0]                          instr_addr_o,
  input  logic [31:0]                          instr_rdata_i,
  output logic                                 outstanding_o,
  instr_if.producer                            out_if
);

  localparam int unsigned OutW = $clog2(`CORE_MAX_OUTST + 1);

  logic                  started_q;
  logic [`CORE_PC_W-1:0] pc_q, rsp_pc_q, stale_pc_q, req_pc;
  logic [OutW-1:0]       outst_q, outst_d;
  logic [OutW-1:0]       discard_q, discard_d;
  logic                  req_hold_q, stale_q;
  logic                  issue_ok, grant, drop, push;

  // Budget keeps room in the buffer for every response in flight
  assign issue_ok = started_q & ~sleep_i &
                    (int'(outst_q) < `CORE_MAX_OUTST) &
                    (int'(outst_q) + int'(buf_fill_i) < `CORE_BUF_DEPTH);

  // A request stays up until granted
  assign instr_req_o  = stale_q | req_hold_q | issue_ok;
  assign req_pc       = stale_q ? stale_pc_q : pc_q;
  assign instr_addr_o = 32'(req_pc) << 2;
  assign grant        = instr_req_o & instr_gnt_i;

  // Responses to requests from before a redirect are dropped
  assign drop          = instr_rvalid_i & (discard_q != '0);
  assign out_if.valid  = instr_rvalid_i & (discard_q == '0) & ~out_if.flush;
  assign out_if.instr  = core_pkg::instr_t'(instr_rdata_i);
  assign out_if.pc     = rsp_pc_q;
  assign push          = out_if.valid & out_if.ready;
  assign outstanding_o = (outst_q != '0) | instr_req_o;

  always_comb begin
    outst_d = outst_q;
    if (grant) begin
      outst_d = outst_d + 1'b1;
    end
    if (instr_rvalid_i) begin
      outst_d = outst_d - 1'b1;
    end
    discard_d = discard_q;
    if (redirect_i) begin
      // Whatever is still in flight belongs to the old path
      discard_d = outst_d;
    end else begin
      if (grant && stale_q) begin
        discard_d = discard_d + 1'b1;
      end
      if (drop) begin
        discard_d = discard_d - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q  <= 1'b0;
      pc_q       <= '0;
      rsp_pc_q   <= '0;
      outst_q    <= '0;
      discard_q  <= '0;
      req_hold_q <= 1'b0;
      stale_q    <= 1'b0;
    end else begin
      outst_q   <= outst_d;
      discard_q <= discard_d;
      if (!started_q) begin
        if (fetch_enable_i) begin
          started_q <= 1'b1;
          pc_q      <= boot_addr_i[`CORE_PC_W+1:2];
          rsp_pc_q  <= boot_addr_i[`CORE_PC_W+1:2];
        end
      end else if (redirect_i) begin
        pc_q     <= redirect_pc_i;
        rsp_pc_q <= redirect_pc_i;
      end else begin
        if (grant && !stale_q) begin
          pc_q <= pc_q + 1'b1;
        end
        if (push) begin
          rsp_pc_q <= rsp_pc_q + 1'b1;
        end
      end
      req_hold_q <= instr_req_o & ~instr_gnt_i & ~redirect_i & ~stale_q;
      stale_q    <= stale_q ? ~instr_gnt_i : (instr_req_o & ~instr_gnt_i & redirect_i);
    end
  end

  // Old address held for an ungranted request cut off by a redirect
  always_ff @(posedge clk_i) begin
    if (instr_req_o && !instr_gnt_i && redirect_i && !stale_q) begin
      stale_pc_q <= pc_q;
    end
  end

endmodule

`default_nettype wire

//--- logic/instr_buffer.sv
////////////////////////////////////////
// Instruction buffer
// Circular FIFO between fetch and
// execute with a one-cycle flush
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module instr_buffer (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  instr_if.consumer                            in_if,
  instr_if.producer                            out_if,
  input  logic                                 flush_i,
  output logic [$clog2(`CORE_BUF_DEPTH+1)-1:0] fill_o
);

  localparam int unsigned PtrW  = $clog2(`CORE_BUF_DEPTH);
  localparam int unsigned FillW = $clog2(`CORE_BUF_DEPTH + 1);

  core_pkg::instr_t      mem_instr [`CORE_BUF_DEPTH];
  logic [`CORE_PC_W-1:0] mem_pc    [`CORE_BUF_DEPTH];

  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [FillW-1:0] count_q;
  logic             push, pop;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign in_if.ready  = (count_q != FillW'(`CORE_BUF_DEPTH));
  assign push         = in_if.valid & in_if.ready;
  assign out_if.valid = (count_q != '0);
  assign pop          = out_if.valid & out_if.ready;

  // Head entry straight from storage
  assign out_if.instr = mem_instr[rptr_q];
  assign out_if.pc    = mem_pc[rptr_q];

  // Let the producer see the flush too
  assign in_if.flush  = flush_i;
  assign fill_o       = count_q;

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      count_q <= count_q + FillW'(push) - FillW'(pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_instr[wptr_q] <= in_if.instr;
      mem_pc[wptr_q]    <= in_if.pc;
    end
  end

endmodule

`default_nettype wire

//--- exec/exec_unit.sv
////////////////////////////////////////
// Execute unit
// Decodes the accumulator instruction
// set and drives the output port
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module exec_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   irq_i,
  instr_if.consumer              in_if,
  output logic                   redirect_o,
  output logic [`CORE_PC_W-1:0]  redirect_pc_o,
  output logic                   sleep_o,
  output logic                   out_valid_o,
  output logic [`CORE_ACC_W-1:0] out_data_o
);

  core_pkg::exec_state_e   state_q, state_d;
  logic [`CORE_ACC_W-1:0]  acc_q, acc_d;
  logic [`CORE_ACC_W-1:0]  imm;
  logic                    consume;
  logic                    emit;
  logic                    jump;
  logic                    out_valid_q;
  logic [`CORE_ACC_W-1:0]  out_data_q;

  // Take one instruction per cycle while running
  assign in_if.ready = (state_q == core_pkg::EX_RUN);
  assign consume     = in_if.valid & in_if.ready;
  assign imm         = `CORE_ACC_W'(in_if.instr.imm);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    emit    = 1'b0;
    jump    = 1'b0;
    if (consume) begin
      case (in_if.instr.opcode)
        core_pkg::OP_LOADI: begin
          acc_d = imm;
        end
        core_pkg::OP_ADDI: begin
          // Wraps at the accumulator width
          acc_d = acc_q + imm;
        end
        core_pkg::OP_XORI: begin
          acc_d = acc_q ^ imm;
        end
        core_pkg::OP_OUT: begin
          emit = 1'b1;
        end
        core_pkg::OP_JMP: begin
          jump = 1'b1;
        end
        core_pkg::OP_WFI: begin
          state_d = core_pkg::EX_SLEEP;
        end
        default: begin
          // NOP and unknown codes
        end
      endcase
    end else if (state_q == core_pkg::EX_SLEEP && irq_i) begin
      state_d = core_pkg::EX_RUN;
    end
  end

  // Jump flushes the buffer and restarts fetch in the same cycle
  assign in_if.flush   = jump;
  assign redirect_o    = jump;
  assign redirect_pc_o = `CORE_PC_W'(in_if.instr.imm);
  assign sleep_o       = (state_q == core_pkg::EX_SLEEP);

  ////////////////////////////////////////
  // State and output port
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= core_pkg::EX_RUN;
      acc_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      acc_q       <= acc_d;
      out_valid_q <= emit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      out_data_q <= acc_q;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

endmodule

`default_nettype wire

//--- logic/clock_gate.sv
////////////////////////////////////////
// Clock gate
// Glitch-free gate with a low-phase
// enable latch and test override
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latch;

  // Enable only changes while the clock is low
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | test_en_i;
    end
  end

  assign clk_o = clk_i & en_latch;

endmodule

`default_nettype wire

//--- logic/core_top.sv
////////////////////////////////////////
// Core top level
// Fetch enable, sleep control and the
// clock-gated fetch/buffer/execute core
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module core_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   test_en_i,
  input  logic [31:0]            boot_addr_i,
  input  logic                   fetch_enable_i,
  input  logic                   irq_i,

  // Instruction memory
  output logic                   instr_req_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  output logic [31:0]            instr_addr_o,
  input  logic [31:0]            instr_rdata_i,

  // Result port
  output logic                   out_valid_o,
  output logic [`CORE_ACC_W-1:0] out_data_o,

  output logic                   core_sleep_o
);

  logic                                 clk_core;
  logic                                 clock_en;
  logic                                 fetch_enable_q;
  logic                                 busy_d, busy_q;
  logic                                 exec_sleep;
  logic                                 fetch_outst;
  logic                                 redirect;
  logic [`CORE_PC_W-1:0]                redirect_pc;
  logic [$clog2(`CORE_BUF_DEPTH+1)-1:0] buf_fill;

  instr_if fetch_to_buf ();
  instr_if buf_to_exec ();

  ////////////////////////////////////////
  // Sleep control on the free clock
  ////////////////////////////////////////

  // Busy while executing or waiting on memory
  // An interrupt keeps the clock up through the wake-up cycle
  assign busy_d = ~exec_sleep | fetch_outst | irq_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
      busy_q         <= 1'b0;
    end else begin
      fetch_enable_q <= fetch_enable_q | fetch_enable_i;
      busy_q         <= busy_d;
    end
  end

  assign clock_en     = fetch_enable_q & (busy_q | irq_i);
  assign core_sleep_o = fetch_enable_q & ~clock_en;

  clock_gate u_clock_gate (
    .clk_i     (clk_i),
    .en_i      (clock_en),
    .test_en_i (test_en_i),
    .clk_o     (clk_core)
  );

  ////////////////////////////////////////
  // Core on the gated clock
  ////////////////////////////////////////

  fetch_unit u_fetch (
    .clk_i          (clk_core),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_q),
    .boot_addr_i    (boot_addr_i),
    .sleep_i        (exec_sleep),
    .buf_fill_i     (buf_fill),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .outstanding_o  (fetch_outst),
    .out_if         (fetch_to_buf)
  );

  instr_buffer u_buffer (
    .clk_i   (clk_core),
    .rst_ni  (rst_ni),
    .in_if   (fetch_to_buf),
    .out_if  (buf_to_exec),
    .flush_i (buf_to_exec.flush),
    .fill_o  (buf_fill)
  );

  exec_unit u_exec (
    .clk_i         (clk_core),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .in_if         (buf_to_exec),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .sleep_o       (exec_sleep),
    .out_valid_o   (out_valid_o),
    .out_data_o    (out_data_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_core.sv
////////////////////////////////////////
// Core testbench
// Random program, memory model with
// random delays and an output model
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module tb_core;

  localparam int MemWords      = 64;
  localparam int BootWord      = 8;
  localparam int LastWord      = MemWords - 1;
  localparam int WfiWordA      = 24;
  localparam int WfiWordB      = 44;
  localparam int TimeoutCycles = 20 * MemWords + 200;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   test_en_i;
  logic [31:0]            boot_addr_i;
  logic                   fetch_enable_i;
  logic                   irq_i;
  logic                   instr_req_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  logic [31:0]            instr_addr_o;
  logic [31:0]            instr_rdata_i;
  logic                   out_valid_o;
  logic [`CORE_ACC_W-1:0] out_data_o;
  logic                   core_sleep_o;

  core_pkg::instr_t       mem [MemWords];
  integer                 seed = 76993;
  int                     errors = 0;
  int                     cycle = 0;
  int                     outs_seen = 0;
  bit                     fe_seen = 1'b0;
  logic [`CORE_ACC_W-1:0] exp_q [$];
  int                     wfi_before [$];

  // Memory model state
  int          gnt_wait = 0;
  int          grants = 0;
  int          rvalids = 0;
  int          last_due = -1;
  bit          first_grant = 1'b1;
  logic        req_prev = 1'b0;
  logic        gnt_prev = 1'b0;
  logic [31:0] addr_prev = '0;
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q [$];

  core_top u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .boot_addr_i    (boot_addr_i),
    .fetch_enable_i (fetch_enable_i),
    .irq_i          (irq_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o),
    .core_sleep_o   (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      errors++;
    end
  endtask

  function automatic int rand_range(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic core_pkg::instr_t make_instr(input core_pkg::opcode_e op,
                                                  input logic [15:0] imm);
    core_pkg::instr_t w;
    w.opcode = op;
    w.rsvd   = 8'h00;
    w.imm    = imm;
    return w;
  endfunction

  ////////////////////////////////////////
  // Program and reference model
  ////////////////////////////////////////

  task automatic build_program();
    int r;
    int t;
    bit ok;
    for (int i = 0; i < BootWord; i++) begin
      mem[i] = core_pkg::instr_t'($random(seed));
    end
    for (int i = BootWord; i < LastWord; i++) begin
      r = rand_range(10);
      if (i == WfiWordA || i == WfiWordB) begin
        mem[i] = make_instr(core_pkg::OP_WFI, 16'h0);
      end else if (r < 2) begin
        mem[i] = make_instr(core_pkg::OP_LOADI, 16'($random(seed)));
      end else if (r < 4) begin
        mem[i] = make_instr(core_pkg::OP_ADDI, 16'($random(seed)));
      end else if (r == 4) begin
        mem[i] = make_instr(core_pkg::OP_XORI, 16'($random(seed)));
      end else if (r < 8) begin
        mem[i] = make_instr(core_pkg::OP_OUT, 16'($random(seed)));
      end else if (r == 8) begin
        mem[i] = make_instr(core_pkg::OP_NOP, 16'h0);
      end else begin
        // Forward jump that never hops over a WFI
        t  = i + 2 + rand_range(3);
        ok = (t < LastWord);
        for (int j = i + 1; j < t; j++) begin
          if (j == WfiWordA || j == WfiWordB) begin
            ok = 1'b0;
          end
        end
        mem[i] = ok ? make_instr(core_pkg::OP_JMP, 16'(t)) : make_instr(core_pkg::OP_NOP, 16'h0);
      end
    end
    mem[LastWord] = make_instr(core_pkg::OP_JMP, 16'(LastWord));
  endtask

  task automatic build_expected();
    int                     pc;
    int                     steps;
    logic [`CORE_ACC_W-1:0] acc;
    core_pkg::instr_t       w;
    pc    = BootWord;
    acc   = '0;
    steps = 0;
    while (pc != LastWord && steps < 1000) begin
      w = mem[pc];
      steps++;
      pc++;
      case (w.opcode)
        core_pkg::OP_LOADI: acc = w.imm;
        core_pkg::OP_ADDI:  acc = acc + w.imm;
        core_pkg::OP_XORI:  acc = acc ^ w.imm;
        core_pkg::OP_OUT:   exp_q.push_back(acc);
        core_pkg::OP_JMP:   pc = int'(w.imm);
        core_pkg::OP_WFI:   wfi_before.push_back(exp_q.size());
        default: begin
        end
      endcase
    end
  endtask

  ////////////////////////////////////////
  // Memory model and protocol checks
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    int                    due;
    core_pkg::exec_state_e ex_state;
    cycle++;
    if (cycle >= TimeoutCycles) begin
      ex_state = u_dut.u_exec.state_q;
      $display("Timeout after %0d cycles, the core did not finish the program", cycle);
      $display("Execute unit was in state %s", ex_state.name());
      $display("Summary: %0d outputs seen, %0d errors", outs_seen, errors + 1);
      $display("sim failed");
      $finish;
    end else begin
      if (rst_ni) begin
        if (instr_req_o && !fe_seen) begin
          $display("Protocol error: request raised before fetch enable");
          errors++;
        end
        if (req_prev && !gnt_prev && (!instr_req_o || instr_addr_o !== addr_prev)) begin
          $display("Protocol error: request dropped or address changed before grant");
          errors++;
        end
        if (instr_req_o && instr_gnt_i) begin
          grants++;
          if (first_grant) begin
            check_value("instr_addr_o", instr_addr_o, boot_addr_i);
            first_grant = 1'b0;
          end
          due = cycle + rand_range(3);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rsp_addr_q.push_back(instr_addr_o);
          rsp_due_q.push_back(due);
          gnt_wait = rand_range(3);
        end
        if (instr_rvalid_i) begin
          rvalids++;
          if (rvalids > grants) begin
            $display("Protocol error: more responses than grants");
            errors++;
          end
        end
        if (grants - rvalids > `CORE_MAX_OUTST) begin
          $display("Protocol error: more than %0d requests in flight", `CORE_MAX_OUTST);
          errors++;
        end
        req_prev  = instr_req_o;
        gnt_prev  = instr_gnt_i;
        addr_prev = instr_addr_o;
      end
      #1;
      if (!rst_ni) begin
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
      end else begin
        if (instr_req_o && gnt_wait == 0) begin
          instr_gnt_i = 1'b1;
        end else begin
          instr_gnt_i = 1'b0;
          if (instr_req_o) begin
            gnt_wait--;
          end
        end
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = 32'(mem[(rsp_addr_q[0] >> 2) % MemWords]);
          void'(rsp_due_q.pop_front());
          void'(rsp_addr_q.pop_front());
        end else begin
          instr_rvalid_i = 1'b0;
          instr_rdata_i  = '0;
        end
      end
    end
  end

  // Output port against the model queue
  always @(posedge clk_i) begin
    if (rst_ni && out_valid_o) begin
      if (core_sleep_o) begin
        $display("Output pulse seen while the core reports sleep");
        errors++;
      end
      if (exp_q.size() == 0) begin
        $display("Unexpected output pulse with data %h", out_data_o);
        errors++;
      end else begin
        check_value("out_data_o", 32'(out_data_o), 32'(exp_q.pop_front()));
      end
      outs_seen++;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    test_en_i      = 1'b0;
    boot_addr_i    = 32'(BootWord * 4);
    fetch_enable_i = 1'b0;
    irq_i          = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    build_program();
    build_expected();
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    // Idle core must not fetch yet
    repeat (10) @(posedge clk_i);
    #1;
    fetch_enable_i = 1'b1;
    fe_seen        = 1'b1;
    for (int k = 0; k < wfi_before.size(); k++) begin
      while (!core_sleep_o) begin
        @(posedge clk_i);
        #1;
      end
      check_value("outputs before WFI", 32'(outs_seen), 32'(wfi_before[k]));
      repeat (6) @(posedge clk_i);
      #1 irq_i = 1'b1;
      @(posedge clk_i);
      #1 irq_i = 1'b0;
      // Wake-up ends once the core fetches or outputs again
      while (!instr_req_o && !out_valid_o) begin
        @(posedge clk_i);
        #1;
      end
      check_value("core_sleep_o", 32'(core_sleep_o), 32'h0);
    end
    while (exp_q.size() > 0) begin
      @(posedge clk_i);
      #1;
    end
    // Catch any late extra pulse
    repeat (30) @(posedge clk_i);
    #1;
    $display("Summary: %0d outputs seen, %0d grants, %0d errors", outs_seen, grants, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/core_pkg.sv
common/instr_if.sv
fetch/fetch_unit.sv
logic/instr_buffer.sv
exec/exec_unit.sv
logic/clock_gate.sv
logic/core_top.sv
dv/tb_core.sv

//--- Makefile
SRCS := $(shell grep -v '^+' all.f) common/core_params.svh

.PHONY: all run clean

all: obj_dir/Vtb_core

obj_dir/Vtb_core: all.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_core -f all.f -o Vtb_core

run: obj_dir/Vtb_core
	@out="$$(./obj_dir/Vtb_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir
